//--- rtl/fifo_consts.svh
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// wide write side, narrow read side
`define FIFO_W_DATA_W  32
`define FIFO_R_DATA_W  8

// width ratio, also the number of banks
`define FIFO_N         4

// address widths in narrow items and in bank rows
`define FIFO_ADDR_W    6
`define FIFO_SEL_W     2
`define FIFO_MINADDR_W 4

// capacity in narrow items
`define FIFO_SIZE      64

`endif

//--- rtl/fifo_pkg.sv
`include "fifo_consts.svh"

package fifo_pkg;

  // one word on the write side
  typedef logic [`FIFO_W_DATA_W-1:0] w_data_t;

  // one item on the read side, same width as a bank word
  typedef logic [`FIFO_R_DATA_W-1:0] r_data_t;

  // bank row address, doubles as the write counter
  typedef logic [`FIFO_MINADDR_W-1:0] bank_addr_t;

  // read counter in narrow items
  typedef logic [`FIFO_ADDR_W-1:0] r_addr_t;

  // fill level, one extra bit to reach FIFO_SIZE
  typedef logic [`FIFO_ADDR_W:0] level_t;

endpackage

//--- rtl/fifo_ctrl.sv
`timescale 1ns/1ns
`include "fifo_consts.svh"

module fifo_ctrl (
  input  logic             clk_i,
  input  logic             reset_i,

  // user strobes
  input  logic             w_en_i,
  input  logic             r_en_i,

  // accepted strobes towards the ports
  output logic             w_accept_o,
  output logic             r_accept_o,

  // status
  output logic             w_full_o,
  output logic             r_empty_o,
  output fifo_pkg::level_t level_o
);

  // a write adds a whole word of narrow items
  localparam fifo_pkg::level_t W_INCR = `FIFO_N;
  localparam fifo_pkg::level_t R_INCR = 1;

  // no room for one more word above this level
  localparam fifo_pkg::level_t FULL_THR = `FIFO_SIZE - `FIFO_N;

  fifo_pkg::level_t level_q;
  fifo_pkg::level_t level_nxt;
  logic             w_full_nxt;
  logic             r_empty_nxt;
  logic             w_full_q;
  logic             r_empty_q;

  // strobes only count while the flags allow them
  assign w_accept_o = w_en_i & ~w_full_q;
  assign r_accept_o = r_en_i & ~r_empty_q;

  // next level from the accepted strobes
  always_comb begin
    level_nxt = level_q;
    case ({w_accept_o, r_accept_o})
      2'b10: begin
        level_nxt = level_q + W_INCR;
      end
      2'b01: begin
        level_nxt = level_q - R_INCR;
      end
      2'b11: begin
        level_nxt = level_q + W_INCR - R_INCR;
      end
      default: begin
        level_nxt = level_q;
      end
    endcase
  end

  // flags derived from the next level, so they line up with it
  assign r_empty_nxt = (level_nxt < R_INCR);
  assign w_full_nxt  = (level_nxt > FULL_THR);

  // level register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      level_q <= '0;
    end else begin
      level_q <= level_nxt;
    end
  end

  // empty flag, set out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_empty_q <= 1'b1;
    end else begin
      r_empty_q <= r_empty_nxt;
    end
  end

  // full flag
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      w_full_q <= 1'b0;
    end else begin
      w_full_q <= w_full_nxt;
    end
  end

  assign level_o   = level_q;
  assign w_full_o  = w_full_q;
  assign r_empty_o = r_empty_q;

endmodule

//--- rtl/fifo_ram_2p.sv
`timescale 1ns/1ns
`include "fifo_consts.svh"

module fifo_ram_2p (
  input  logic                 clk_i,

  // write port
  input  logic                 w_en_i,
  input  fifo_pkg::bank_addr_t w_addr_i,
  input  fifo_pkg::r_data_t    w_data_i,

  // read port
  input  logic                 r_en_i,
  input  fifo_pkg::bank_addr_t r_addr_i,
  output fifo_pkg::r_data_t    r_data_o
);

  localparam int DEPTH = 1 << `FIFO_MINADDR_W;

  fifo_pkg::r_data_t mem [DEPTH];

  always_ff @(posedge clk_i) begin
    if (w_en_i) begin
      mem[w_addr_i] <= w_data_i;
    end
  end

  // output register holds while the bank is not read
  always_ff @(posedge clk_i) begin
    if (r_en_i) begin
      r_data_o <= mem[r_addr_i];
    end
  end

endmodule

//--- rtl/fifo_wr_port.sv
`timescale 1ns/1ns
`include "fifo_consts.svh"

module fifo_wr_port (
  input  logic                 clk_i,
  input  logic                 reset_i,

  // accepted write and its word
  input  logic                 w_accept_i,
  input  fifo_pkg::w_data_t    w_data_i,

  // towards the banks
  output logic [`FIFO_N-1:0]   bank_w_en_o,
  output fifo_pkg::bank_addr_t bank_w_addr_o,
  output fifo_pkg::r_data_t    bank_w_data_o [`FIFO_N]
);

  fifo_pkg::bank_addr_t w_addr_q;

  // one row per word, wraps at the bank depth
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      w_addr_q <= '0;
    end else if (w_accept_i) begin
      w_addr_q <= w_addr_q + 1'b1;
    end
  end

  // every bank takes its slice of the word
  assign bank_w_en_o   = {`FIFO_N{w_accept_i}};
  assign bank_w_addr_o = w_addr_q;

  // slice k goes to bank k, lowest slice read first
  always_comb begin
    for (int k = 0; k < `FIFO_N; k++) begin
      bank_w_data_o[k] = w_data_i[k*`FIFO_R_DATA_W +: `FIFO_R_DATA_W];
    end
  end

endmodule

//--- rtl/fifo_rd_port.sv
`timescale 1ns/1ns
`include "fifo_consts.svh"

module fifo_rd_port (
  input  logic                 clk_i,
  input  logic                 reset_i,

  // accepted read
  input  logic                 r_accept_i,

  // bank side
  input  fifo_pkg::r_data_t    bank_r_data_i [`FIFO_N],
  output logic [`FIFO_N-1:0]   bank_r_en_o,
  output fifo_pkg::bank_addr_t bank_r_addr_o,

  // narrow output
  output fifo_pkg::r_data_t    r_data_o
);

  fifo_pkg::r_addr_t       r_addr_q;
  logic [`FIFO_SEL_W-1:0]  sel_q;
  logic                    rd_done_q;

  // read counter in narrow items that wraps at FIFO_SIZE
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_addr_q <= '0;
    end else if (r_accept_i) begin
      r_addr_q <= r_addr_q + 1'b1;
    end
  end

  // upper bits pick the row and lower bits the bank
  assign bank_r_addr_o = r_addr_q[`FIFO_ADDR_W-1:`FIFO_SEL_W];

  always_comb begin
    bank_r_en_o = '0;
    if (r_accept_i) begin
      bank_r_en_o[r_addr_q[`FIFO_SEL_W-1:0]] = 1'b1;
    end
  end

  // bank select registered alongside the bank output register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q     <= '0;
      rd_done_q <= 1'b0;
    end else if (r_accept_i) begin
      sel_q     <= r_addr_q[`FIFO_SEL_W-1:0];
      rd_done_q <= 1'b1;
    end
  end

  // zero until the first read since reset has landed
  assign r_data_o = rd_done_q ? bank_r_data_i[sel_q] : '0;

endmodule

//--- rtl/fifo_sync_asym.sv
`timescale 1ns/1ns
`include "fifo_consts.svh"

module fifo_sync_asym (
  input  logic              clk_i,
  input  logic              reset_i,

  // write side
  input  logic              w_en_i,
  input  fifo_pkg::w_data_t w_data_i,
  output logic              w_full_o,

  // read side
  input  logic              r_en_i,
  output fifo_pkg::r_data_t r_data_o,
  output logic              r_empty_o,

  // fill level in narrow items
  output fifo_pkg::level_t  level_o
);

  logic                 w_accept;
  logic                 r_accept;

  // write port to banks
  logic [`FIFO_N-1:0]   bank_w_en;
  fifo_pkg::bank_addr_t bank_w_addr;
  fifo_pkg::r_data_t    bank_w_data [`FIFO_N];

  // read port to banks
  logic [`FIFO_N-1:0]   bank_r_en;
  fifo_pkg::bank_addr_t bank_r_addr;
  fifo_pkg::r_data_t    bank_r_data [`FIFO_N];

  fifo_ctrl ctrl0 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .w_en_i     (w_en_i),
    .r_en_i     (r_en_i),
    .w_accept_o (w_accept),
    .r_accept_o (r_accept),
    .w_full_o   (w_full_o),
    .r_empty_o  (r_empty_o),
    .level_o    (level_o)
  );

  fifo_wr_port wr_port0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .w_accept_i    (w_accept),
    .w_data_i      (w_data_i),
    .bank_w_en_o   (bank_w_en),
    .bank_w_addr_o (bank_w_addr),
    .bank_w_data_o (bank_w_data)
  );

  fifo_rd_port rd_port0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .r_accept_i    (r_accept),
    .bank_r_data_i (bank_r_data),
    .bank_r_en_o   (bank_r_en),
    .bank_r_addr_o (bank_r_addr),
    .r_data_o      (r_data_o)
  );

  // one narrow bank per slice of the wide word
  for (genvar k = 0; k < `FIFO_N; k++) begin : g_bank
    fifo_ram_2p ram0 (
      .clk_i    (clk_i),
      .w_en_i   (bank_w_en[k]),
      .w_addr_i (bank_w_addr),
      .w_data_i (bank_w_data[k]),
      .r_en_i   (bank_r_en[k]),
      .r_addr_i (bank_r_addr),
      .r_data_o (bank_r_data[k])
    );
  end

endmodule

//--- bench/tb_fifo_sync_asym.sv
`timescale 1ns/1ns
`include "fifo_consts.svh"

module tb_fifo_sync_asym;

  // upper bound on the cycles of the directed tests
  localparam int DIRECTED_CYCLES = 200;
  localparam int MIXED_CYCLES    = 300;
  // test length with a fourfold margin
  localparam int WATCHDOG_CYCLES = 4 * (DIRECTED_CYCLES + MIXED_CYCLES);
  localparam int FULL_THR        = `FIFO_SIZE - `FIFO_N;

  logic              clk_i;
  logic              reset_i;
  logic              w_en_i;
  fifo_pkg::w_data_t w_data_i;
  logic              r_en_i;
  logic              w_full_o;
  fifo_pkg::r_data_t r_data_o;
  logic              r_empty_o;
  fifo_pkg::level_t  level_o;

  // reference model of the narrow items in read order
  fifo_pkg::r_data_t model_q [$];
  fifo_pkg::r_data_t last_rd;
  integer            seed;
  string             test_name;
  int                both_count;

  fifo_sync_asym dut (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .w_en_i    (w_en_i),
    .w_data_i  (w_data_i),
    .w_full_o  (w_full_o),
    .r_en_i    (r_en_i),
    .r_data_o  (r_data_o),
    .r_empty_o (r_empty_o),
    .level_o   (level_o)
  );

  always #5 clk_i = ~clk_i;

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("** FAIL **");
    $fatal(1, "timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
  end

  task automatic check_data(input string what, input fifo_pkg::r_data_t exp,
                            input fifo_pkg::r_data_t act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %02h, actual %02h", test_name, what, exp, act);
      $display("** FAIL **");
      $fatal(1, "read data is wrong");
    end
  endtask

  task automatic check_level(input string what, input fifo_pkg::level_t exp,
                             input fifo_pkg::level_t act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      $display("** FAIL **");
      $fatal(1, "fill level is wrong");
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %0b, actual %0b", test_name, what, exp, act);
      $display("** FAIL **");
      $fatal(1, "status flag is wrong");
    end
  endtask

  function automatic fifo_pkg::r_data_t word_item(input fifo_pkg::w_data_t w, input int k);
    return w[k*`FIFO_R_DATA_W +: `FIFO_R_DATA_W];
  endfunction

  // drive one cycle of strobes, check the strobe taken at this edge,
  // then predict the new one from the count the flags will show
  task automatic drive_cycle(input logic we, input fifo_pkg::w_data_t wd, input logic re);
    int count;
    @(posedge clk_i);
    w_en_i   <= we;
    w_data_i <= wd;
    r_en_i   <= re;
    @(negedge clk_i);
    count = model_q.size();
    check_level("level", fifo_pkg::level_t'(count), level_o);
    check_flag("empty", count < 1, r_empty_o);
    check_flag("full", count > FULL_THR, w_full_o);
    check_data("read data", last_rd, r_data_o);
    if (re && count >= 1 && we && count <= FULL_THR) begin
      both_count++;
    end
    if (re && count >= 1) begin
      last_rd = model_q.pop_front();
    end
    if (we && count <= FULL_THR) begin
      for (int k = 0; k < `FIFO_N; k++) begin
        model_q.push_back(word_item(wd, k));
      end
    end
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, 1'b0);
  endtask

  task automatic test_reset();
    test_name = "test_reset";
    idle_cycle();
    check_level("level after reset", fifo_pkg::level_t'(0), level_o);
    check_flag("empty after reset", 1'b1, r_empty_o);
    check_flag("full after reset", 1'b0, w_full_o);
  endtask

  task automatic test_single_word();
    fifo_pkg::w_data_t word;
    test_name = "test_single_word";
    word = $random(seed);
    drive_cycle(1'b1, word, 1'b0);
    idle_cycle();
    check_level("level after write", fifo_pkg::level_t'(`FIFO_N), level_o);
    check_flag("empty after write", 1'b0, r_empty_o);
    // lowest byte comes out first
    for (int i = 0; i < `FIFO_N; i++) begin
      drive_cycle(1'b0, '0, 1'b1);
      idle_cycle();
      check_data("byte", word_item(word, i), r_data_o);
    end
    check_level("level after reads", fifo_pkg::level_t'(0), level_o);
    check_flag("empty after reads", 1'b1, r_empty_o);
  endtask

  task automatic test_fill();
    fifo_pkg::w_data_t words [`FIFO_SIZE/`FIFO_N + 1];
    test_name = "test_fill";
    for (int i = 0; i <= `FIFO_SIZE/`FIFO_N; i++) begin
      words[i] = $random(seed);
    end
    for (int i = 0; i < `FIFO_SIZE/`FIFO_N - 1; i++) begin
      drive_cycle(1'b1, words[i], 1'b0);
    end
    idle_cycle();
    check_level("level at 15 words", fifo_pkg::level_t'(FULL_THR), level_o);
    check_flag("full at 15 words", 1'b0, w_full_o);
    drive_cycle(1'b1, words[`FIFO_SIZE/`FIFO_N - 1], 1'b0);
    idle_cycle();
    check_level("level at 16 words", fifo_pkg::level_t'(`FIFO_SIZE), level_o);
    check_flag("full at 16 words", 1'b1, w_full_o);
    // one word too many
    drive_cycle(1'b1, words[`FIFO_SIZE/`FIFO_N], 1'b0);
    idle_cycle();
    check_level("level after refused write", fifo_pkg::level_t'(`FIFO_SIZE), level_o);
    // back to back reads where each item shows one cycle after its read
    for (int i = 0; i < `FIFO_SIZE; i++) begin
      drive_cycle(1'b0, '0, 1'b1);
      if (i > 0) begin
        check_data("drained item", word_item(words[(i-1)/`FIFO_N], (i-1)%`FIFO_N), r_data_o);
      end
    end
    idle_cycle();
    check_data("drained item", word_item(words[`FIFO_SIZE/`FIFO_N - 1], `FIFO_N - 1),
               r_data_o);
    check_level("level after drain", fifo_pkg::level_t'(0), level_o);
    check_flag("empty after drain", 1'b1, r_empty_o);
  endtask

  task automatic test_empty_read();
    fifo_pkg::r_data_t hold;
    test_name = "test_empty_read";
    hold = last_rd;
    repeat (5) begin
      drive_cycle(1'b0, '0, 1'b1);
      idle_cycle();
    end
    check_level("level after empty reads", fifo_pkg::level_t'(0), level_o);
    check_flag("empty after empty reads", 1'b1, r_empty_o);
    check_data("held data", hold, r_data_o);
  endtask

  task automatic test_mixed();
    logic              we;
    logic              re;
    fifo_pkg::w_data_t word;
    test_name = "test_mixed";
    both_count = 0;
    for (int i = 0; i < MIXED_CYCLES; i++) begin
      word = $random(seed);
      // fills towards full in the first half and drains in the second
      if (i < MIXED_CYCLES/2) begin
        we = ($random(seed) & 32'h3) == 0;
        re = ($random(seed) & 32'h1) != 0;
      end else begin
        we = ($random(seed) & 32'h7) == 0;
        re = ($random(seed) & 32'h7) != 0;
      end
      drive_cycle(we, word, re);
    end
    idle_cycle();
    if (both_count == 0) begin
      $display("** FAIL **");
      $fatal(1, "test_mixed never had a write and a read accepted in the same cycle");
    end
  endtask

  initial begin
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    w_en_i     = 1'b0;
    w_data_i   = '0;
    r_en_i     = 1'b0;
    seed       = 32'h3319_ec8b;
    last_rd    = '0;
    both_count = 0;
    model_q.delete();
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    test_reset();
    test_single_word();
    test_fill();
    test_empty_read();
    test_mixed();
    $display("** PASS **");
    $finish;
  end

endmodule

//--- compile.f
+incdir+rtl
rtl/fifo_pkg.sv
rtl/fifo_ctrl.sv
rtl/fifo_ram_2p.sv
rtl/fifo_wr_port.sv
rtl/fifo_rd_port.sv
rtl/fifo_sync_asym.sv
bench/tb_fifo_sync_asym.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary -j 0 -Wno-fatal
TOP       := tb_fifo_sync_asym
FILELIST  := compile.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

# build, then run; a $fatal in the bench gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
